//--- design/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// word addresses inside the register window
	localparam logic [2:0] ADDR_CTRL = 3'd2;
	localparam logic [2:0] ADDR_MODE = 3'd3;
	localparam logic [2:0] ADDR_BASE_HI = 3'd4;
	localparam logic [2:0] ADDR_BASE_MID = 3'd5;
	localparam logic [2:0] ADDR_BASE_LO = 3'd6;

	// mode register fields
	localparam int MODE_REG_LO = 1;
	localparam int MODE_REG_HI = 2;
	localparam int MODE_ACSI = 3;
	localparam int MODE_SCNT = 4;

	// floppy register select, from mode bits 2..1
	localparam logic [1:0] FDC_REG_CMD = 2'd0;
	localparam logic [1:0] FDC_REG_TRACK = 2'd1;
	localparam logic [1:0] FDC_REG_SECTOR = 2'd2;
	localparam logic [1:0] FDC_REG_DATA = 2'd3;

	// motor keeps spinning this many cycles after a command
	localparam logic [15:0] MOTOR_TIME = 16'hffff;
	// busy codes
	localparam logic [1:0] FDC_BUSY_START = 2'd2;
	localparam logic [1:0] FDC_BUSY_WAIT = 2'd3;

	// acsi parameter bytes
	localparam logic [2:0] ACSI_AUTO_BYTES = 3'd4;
	localparam logic [2:0] ACSI_PARM_COUNT = 3'd5;

	// one cpu bus cycle
	typedef struct packed {
		logic sel;
		logic rw;
		logic lds;
		logic uds;
		logic [2:0] addr;
		logic [15:0] din;
	} cpu_bus_t;

	// one write into the controller window
	typedef struct packed {
		logic fdc_wr;
		logic acsi_wr;
		logic [1:0] reg_idx;
		logic first;
		logic [7:0] data;
	} ctrl_wr_t;

	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] data;
		logic [7:0] status;
		logic busy;
	} fdc_state_t;

	// parameter byte n sits at parms[8n+7:8n]
	typedef struct packed {
		logic [2:0] target;
		logic [4:0] cmd;
		logic busy;
		logic [8*ACSI_PARM_COUNT-1:0] parms;
	} acsi_state_t;

	typedef struct packed {
		logic [23:0] base;
		logic [7:0] scnt;
	} dma_state_t;

endpackage

`default_nettype wire

//--- design/dma_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dma_regs (
	input wire clk,
	input wire reset,
	input wire dma_pkg::cpu_bus_t bus,
	input wire dma_pkg::fdc_state_t fdc,
	input wire dma_pkg::acsi_state_t acsi,
	input wire ack_pulse,
	output logic [15:0] dout,
	output dma_pkg::ctrl_wr_t ctrl_wr,
	output logic fdc_status_rd,
	output logic acsi_status_rd,
	output dma_pkg::dma_state_t dma
);
	import dma_pkg::*;

	logic [15:0] mode;
	logic [1:0] reg_idx;
	logic bus_wr;
	logic bus_rd;
	// controller window selected, not the sector count
	logic ctrl_win;
	logic ctrl_acsi;

	assign reg_idx = mode[MODE_REG_HI:MODE_REG_LO];
	assign bus_wr = bus.sel && !bus.rw;
	assign bus_rd = bus.sel && bus.rw;
	assign ctrl_win = (bus.addr == ADDR_CTRL) && !mode[MODE_SCNT];
	assign ctrl_acsi = mode[MODE_ACSI];

	// strobes into the two controllers
	always_comb begin
		ctrl_wr.fdc_wr = bus_wr && !bus.lds && ctrl_win && !ctrl_acsi;
		ctrl_wr.acsi_wr = bus_wr && !bus.lds && ctrl_win && ctrl_acsi;
		ctrl_wr.reg_idx = reg_idx;
		// mode bit 1 low marks the acsi command byte
		ctrl_wr.first = !mode[MODE_REG_LO];
		ctrl_wr.data = bus.din[7:0];
	end

	// status reads clear the interrupts
	assign fdc_status_rd = bus_rd && ctrl_win && !ctrl_acsi && (reg_idx == FDC_REG_CMD);
	assign acsi_status_rd = bus_rd && ctrl_win && ctrl_acsi;

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= 16'h0000;
			dma <= '0;
		end else begin
			// io controller finished, all sectors moved
			if (ack_pulse)
				dma.scnt <= 8'h00;
			if (bus_wr) begin
				// mode takes the full word
				if (bus.addr == ADDR_MODE)
					mode <= bus.din;
				if (!bus.lds) begin
					case (bus.addr)
						ADDR_CTRL: begin
							if (mode[MODE_SCNT])
								dma.scnt <= bus.din[7:0];
						end
						ADDR_BASE_HI: dma.base[23:16] <= bus.din[7:0];
						ADDR_BASE_MID: dma.base[15:8] <= bus.din[7:0];
						ADDR_BASE_LO: dma.base[7:0] <= bus.din[7:0];
						default: ;
					endcase
				end
			end
		end
	end

	// read data, zero outside a read cycle
	always_comb begin
		dout = 16'h0000;
		if (bus_rd) begin
			case (bus.addr)
				ADDR_CTRL: begin
					if (mode[MODE_SCNT])
						dout = {8'h00, dma.scnt};
					else if (ctrl_acsi)
						// acsi status, busy at bit 3
						dout = {8'h00, 4'h0, acsi.busy, 3'b000};
					else begin
						case (reg_idx)
							FDC_REG_CMD: dout = {8'h00, fdc.status};
							FDC_REG_TRACK: dout = {8'h00, fdc.track};
							FDC_REG_SECTOR: dout = {8'h00, fdc.sector};
							default: dout = {8'h00, fdc.data};
						endcase
					end
				end
				// dma status, bit 0 always ok
				ADDR_MODE: dout = {14'd0, dma.scnt != 8'h00, 1'b1};
				ADDR_BASE_HI: dout = {8'h00, dma.base[23:16]};
				ADDR_BASE_MID: dout = {8'h00, dma.base[15:8]};
				ADDR_BASE_LO: dout = {8'h00, dma.base[7:0]};
				default: dout = 16'h0000;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/fdc_emu.sv
`timescale 1ns/1ns
`default_nettype none

module fdc_emu (
	input wire clk,
	input wire reset,
	input wire dma_pkg::ctrl_wr_t ctrl_wr,
	input wire fdc_status_rd,
	input wire ack_pulse,
	input wire wr_prot,
	output dma_pkg::fdc_state_t state,
	output logic irq
);
	import dma_pkg::*;

	logic [7:0] cmd;
	logic [7:0] track;
	logic [7:0] sector;
	logic [7:0] data;
	// 0 idle, 2..1 counting down, 3 waiting for io controller
	logic [1:0] busy;
	logic [15:0] motor;
	// 1 means inward, toward higher tracks
	logic step_dir;
	logic cmd_wr;
	logic [7:0] d;

	assign cmd_wr = ctrl_wr.fdc_wr && (ctrl_wr.reg_idx == FDC_REG_CMD);
	assign d = ctrl_wr.data;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd <= 8'h00;
			track <= 8'h00;
			sector <= 8'h00;
			data <= 8'h00;
			busy <= 2'd0;
			motor <= 16'h0000;
			step_dir <= 1'b0;
			irq <= 1'b0;
		end else begin
			// count down unless parked on the io controller
			if ((busy != 2'd0) && (busy != FDC_BUSY_WAIT))
				busy <= busy - 2'd1;
			// ack releases a parked command
			if (ack_pulse && (busy == FDC_BUSY_WAIT))
				busy <= 2'd1;
			// end of busy phase
			if (busy == 2'd1)
				irq <= 1'b1;
			if (fdc_status_rd)
				irq <= 1'b0;
			if (motor != 16'h0000)
				motor <= motor - 16'd1;

			if (cmd_wr) begin
				cmd <= d;
				busy <= FDC_BUSY_START;
				// type I and type II spin the motor up
				if (!d[7] || (d[7:6] == 2'b10))
					motor <= MOTOR_TIME;
				// type I
				if (d[7:4] == 4'b0000)
					track <= 8'h00;
				if (d[7:4] == 4'b0001)
					track <= data;
				// step repeats the last direction
				if (d[7:5] == 3'b001)
					track <= step_dir ? track + 8'd1 : track - 8'd1;
				if (d[7:5] == 3'b010) begin
					step_dir <= 1'b1;
					track <= track + 8'd1;
				end
				if (d[7:5] == 3'b011) begin
					step_dir <= 1'b0;
					track <= track - 8'd1;
				end
				// type II, read and write sector
				if (d[7:5] == 3'b100)
					busy <= FDC_BUSY_WAIT;
				// protected disk, write ends by itself
				if ((d[7:5] == 3'b101) && !wr_prot)
					busy <= FDC_BUSY_WAIT;
				// type III
				if ((d[7:4] == 4'b1100) || (d[7:4] == 4'b1110))
					busy <= FDC_BUSY_WAIT;
				if ((d[7:4] == 4'b1111) && !wr_prot)
					busy <= FDC_BUSY_WAIT;
				// type IV force interrupt
				if (d[7:4] == 4'b1101)
					busy <= 2'd1;
			end

			if (ctrl_wr.fdc_wr) begin
				case (ctrl_wr.reg_idx)
					FDC_REG_TRACK: track <= d;
					FDC_REG_SECTOR: sector <= d;
					FDC_REG_DATA: data <= d;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		state.cmd = cmd;
		state.track = track;
		state.sector = sector;
		state.data = data;
		// motor, protect, track zero for type I only, busy
		state.status = {motor != 16'h0000, wr_prot, 3'b000,
			!cmd[7] && (track == 8'h00), 1'b0, busy != 2'd0};
		state.busy = busy != 2'd0;
	end

endmodule

`default_nettype wire

//--- design/acsi_cmd.sv
`timescale 1ns/1ns
`default_nettype none

module acsi_cmd (
	input wire clk,
	input wire reset,
	input wire dma_pkg::ctrl_wr_t ctrl_wr,
	input wire acsi_status_rd,
	input wire ack_pulse,
	input wire [7:0] acsi_enable,
	output dma_pkg::acsi_state_t state,
	output logic irq
);
	import dma_pkg::*;

	logic [2:0] target;
	logic [4:0] cmd;
	logic busy;
	logic [2:0] byte_cnt;
	logic [8*ACSI_PARM_COUNT-1:0] parms;
	logic first_wr;
	logic parm_wr;

	assign first_wr = ctrl_wr.acsi_wr && ctrl_wr.first;
	// bytes past the last slot are dropped
	assign parm_wr = ctrl_wr.acsi_wr && !ctrl_wr.first && (byte_cnt < ACSI_PARM_COUNT);

	always_ff @(posedge clk) begin
		if (reset) begin
			target <= 3'd0;
			cmd <= 5'd0;
			busy <= 1'b0;
			byte_cnt <= 3'd0;
			parms <= '0;
			irq <= 1'b0;
		end else begin
			// io controller done with the command
			if (ack_pulse && busy) begin
				busy <= 1'b0;
				irq <= 1'b1;
			end
			if (acsi_status_rd)
				irq <= 1'b0;

			if (first_wr) begin
				target <= ctrl_wr.data[7:5];
				cmd <= ctrl_wr.data[4:0];
				byte_cnt <= 3'd0;
				// only enabled targets answer
				if (acsi_enable[ctrl_wr.data[7:5]])
					irq <= 1'b1;
			end

			if (parm_wr) begin
				parms[8*byte_cnt +: 8] <= ctrl_wr.data;
				byte_cnt <= byte_cnt + 3'd1;
				if (acsi_enable[target]) begin
					// auto-ack, last byte goes to the io controller
					if (byte_cnt < ACSI_AUTO_BYTES)
						irq <= 1'b1;
					else
						busy <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		state.target = target;
		state.cmd = cmd;
		state.busy = busy;
		state.parms = parms;
	end

endmodule

`default_nettype wire

//--- design/dio_status.sv
`timescale 1ns/1ns
`default_nettype none

module dio_status (
	input wire clk,
	input wire reset,
	input wire dio_ack,
	input wire [4:0] dio_idx,
	input wire dma_pkg::fdc_state_t fdc,
	input wire dma_pkg::acsi_state_t acsi,
	input wire dma_pkg::dma_state_t dma,
	input wire drive_side,
	input wire [1:0] drive_sel,
	output logic ack_pulse,
	output logic [7:0] dio_data
);
	import dma_pkg::*;

	// two stage synchronizer plus one delay for the edge
	logic ack_s1;
	logic ack_s2;
	logic ack_d;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_s1 <= 1'b0;
			ack_s2 <= 1'b0;
			ack_d <= 1'b0;
		end else begin
			ack_s1 <= dio_ack;
			ack_s2 <= ack_s1;
			ack_d <= ack_s2;
		end
	end

	// rising edge of the synced level
	assign ack_pulse = ack_s2 && !ack_d;

	// indexed status bytes for the io controller
	always_comb begin
		case (dio_idx)
			5'd0: dio_data = dma.base[23:16];
			5'd1: dio_data = dma.base[15:8];
			5'd2: dio_data = dma.base[7:0];
			5'd3: dio_data = dma.scnt;
			5'd4: dio_data = fdc.cmd;
			5'd5: dio_data = fdc.track;
			5'd6: dio_data = fdc.sector;
			5'd7: dio_data = fdc.data;
			// busy flags and drive selection
			5'd8: dio_data = {3'b000, acsi.busy, drive_sel, drive_side, fdc.busy};
			5'd9: dio_data = {acsi.target, acsi.cmd};
			5'd10: dio_data = acsi.parms[7:0];
			5'd11: dio_data = acsi.parms[15:8];
			5'd12: dio_data = acsi.parms[23:16];
			5'd13: dio_data = acsi.parms[31:24];
			5'd14: dio_data = acsi.parms[39:32];
			default: dio_data = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- design/dma.sv
`timescale 1ns/1ns
`default_nettype none

module dma (
	input wire clk,
	input wire reset,
	// cpu side
	input wire dma_pkg::cpu_bus_t bus,
	output logic [15:0] dout,
	output logic irq,
	// system config
	input wire fdc_wr_prot,
	input wire [7:0] acsi_enable,
	// io controller status port
	input wire [4:0] dio_idx,
	output logic [7:0] dio_data,
	input wire dio_ack,
	// drive select lines
	input wire drive_side,
	input wire [1:0] drive_sel
);
	import dma_pkg::*;

	ctrl_wr_t ctrl_wr;
	fdc_state_t fdc_state;
	acsi_state_t acsi_state;
	dma_state_t dma_state;
	logic fdc_status_rd;
	logic acsi_status_rd;
	logic ack_pulse;
	logic fdc_irq;
	logic acsi_irq;

	// register file and bus decode
	dma_regs u_regs (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.fdc(fdc_state),
		.acsi(acsi_state),
		.ack_pulse(ack_pulse),
		.dout(dout),
		.ctrl_wr(ctrl_wr),
		.fdc_status_rd(fdc_status_rd),
		.acsi_status_rd(acsi_status_rd),
		.dma(dma_state)
	);

	fdc_emu u_fdc (
		.clk(clk),
		.reset(reset),
		.ctrl_wr(ctrl_wr),
		.fdc_status_rd(fdc_status_rd),
		.ack_pulse(ack_pulse),
		.wr_prot(fdc_wr_prot),
		.state(fdc_state),
		.irq(fdc_irq)
	);

	acsi_cmd u_acsi (
		.clk(clk),
		.reset(reset),
		.ctrl_wr(ctrl_wr),
		.acsi_status_rd(acsi_status_rd),
		.ack_pulse(ack_pulse),
		.acsi_enable(acsi_enable),
		.state(acsi_state),
		.irq(acsi_irq)
	);

	// ack sync and status bytes
	dio_status u_dio (
		.clk(clk),
		.reset(reset),
		.dio_ack(dio_ack),
		.dio_idx(dio_idx),
		.fdc(fdc_state),
		.acsi(acsi_state),
		.dma(dma_state),
		.drive_side(drive_side),
		.drive_sel(drive_sel),
		.ack_pulse(ack_pulse),
		.dio_data(dio_data)
	);

	// either controller can interrupt
	assign irq = fdc_irq || acsi_irq;

endmodule

`default_nettype wire

//--- sim/dma_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dma_tb;
	import dma_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int SAMPLE_DELAY = 10;
	localparam int ACK_TIMEOUT = 12;

	logic clk;
	logic reset;
	cpu_bus_t bus;
	logic [15:0] dout;
	logic irq;
	logic fdc_wr_prot;
	logic [7:0] acsi_enable;
	logic [4:0] dio_idx;
	logic [7:0] dio_data;
	logic dio_ack;
	logic drive_side;
	logic [1:0] drive_sel;
	// acsi bytes as written, for the capture checks
	logic [2:0] acsi_target;
	logic [4:0] acsi_cmd_code;
	logic [7:0] parm_bytes [5];

	dma u_dut (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.dout(dout),
		.irq(irq),
		.fdc_wr_prot(fdc_wr_prot),
		.acsi_enable(acsi_enable),
		.dio_idx(dio_idx),
		.dio_data(dio_data),
		.dio_ack(dio_ack),
		.drive_side(drive_side),
		.drive_sel(drive_sel)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// expected floppy status byte
	function automatic logic [7:0] fdc_status_byte(input logic motor, input logic wp,
		input logic tz, input logic busy);
		return {motor, wp, 3'b000, tz, 1'b0, busy};
	endfunction

	// expected byte at status index 8
	function automatic logic [7:0] dio_flags(input logic acsi_busy, input logic [1:0] sel,
		input logic side, input logic fdc_busy);
		return {3'b000, acsi_busy, sel, side, fdc_busy};
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic bus_idle();
		bus.sel = 1'b0;
		bus.rw = 1'b1;
		bus.lds = 1'b1;
		bus.uds = 1'b1;
		bus.addr = 3'd0;
		bus.din = 16'h0000;
	endtask

	// one cycle write, sampled on the next edge
	task automatic bus_write(input logic [2:0] addr, input logic [15:0] data);
		bus.sel = 1'b1;
		bus.rw = 1'b0;
		bus.lds = 1'b0;
		bus.uds = 1'b0;
		bus.addr = addr;
		bus.din = data;
		@(posedge clk);
		#DRIVE_DELAY;
		bus_idle();
	endtask

	// dout sampled mid cycle, read strobe seen on the edge
	task automatic bus_read(input logic [2:0] addr, output logic [15:0] data);
		bus.sel = 1'b1;
		bus.rw = 1'b1;
		bus.lds = 1'b0;
		bus.uds = 1'b0;
		bus.addr = addr;
		bus.din = 16'h0000;
		#SAMPLE_DELAY;
		data = dout;
		@(posedge clk);
		#DRIVE_DELAY;
		bus_idle();
	endtask

	task automatic set_mode(input logic [15:0] mode);
		bus_write(ADDR_MODE, mode);
	endtask

	task automatic read_dio(input logic [4:0] idx, output logic [7:0] val);
		dio_idx = idx;
		#1;
		val = dio_data;
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic wait_irq(input string name, input int limit);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			seen = irq;
		end
		assert (seen) else begin
			$display("%s: timed out waiting for the interrupt", name);
			$display("Test failed");
			$fatal(1, "stopping on timeout");
		end
	endtask

	task automatic regfile_test();
		logic [31:0] r;
		logic [15:0] rd;
		logic [7:0] b;
		logic [7:0] expect_bytes [8];
		check_value("regfile irq after reset", 16'h0000, 16'(irq));
		bus_read(ADDR_MODE, rd);
		check_value("regfile dma status idle", 16'h0001, rd);
		r = $urandom();
		// base hi, mid, lo, then count forced non-zero
		expect_bytes[0] = r[7:0];
		expect_bytes[1] = r[15:8];
		expect_bytes[2] = r[23:16];
		expect_bytes[3] = r[31:24] | 8'h01;
		// cmd register untouched since reset
		expect_bytes[4] = 8'h00;
		r = $urandom();
		expect_bytes[5] = r[7:0];
		expect_bytes[6] = r[15:8];
		expect_bytes[7] = r[23:16];
		bus_write(ADDR_BASE_HI, 16'(expect_bytes[0]));
		bus_write(ADDR_BASE_MID, 16'(expect_bytes[1]));
		bus_write(ADDR_BASE_LO, 16'(expect_bytes[2]));
		set_mode(16'h0010);
		bus_write(ADDR_CTRL, 16'(expect_bytes[3]));
		// track, sector, data via mode bits 2..1
		for (int i = 1; i < 4; i++) begin
			set_mode(16'(i * 2));
			bus_write(ADDR_CTRL, 16'(expect_bytes[4 + i]));
		end
		bus_read(ADDR_BASE_HI, rd);
		check_value("regfile base hi", 16'(expect_bytes[0]), rd);
		bus_read(ADDR_BASE_MID, rd);
		check_value("regfile base mid", 16'(expect_bytes[1]), rd);
		bus_read(ADDR_BASE_LO, rd);
		check_value("regfile base lo", 16'(expect_bytes[2]), rd);
		set_mode(16'h0010);
		bus_read(ADDR_CTRL, rd);
		check_value("regfile sector count", 16'(expect_bytes[3]), rd);
		for (int i = 1; i < 4; i++) begin
			set_mode(16'(i * 2));
			bus_read(ADDR_CTRL, rd);
			check_value($sformatf("regfile fdc reg %0d", i), 16'(expect_bytes[4 + i]), rd);
		end
		bus_read(ADDR_MODE, rd);
		check_value("regfile dma status count set", 16'h0003, rd);
		// same values through the status port
		for (int i = 0; i < 8; i++) begin
			read_dio(5'(i), b);
			check_value($sformatf("regfile dio idx %0d", i), 16'(expect_bytes[i]), 16'(b));
		end
		set_mode(16'h0010);
		bus_write(ADDR_CTRL, 16'h0000);
		bus_read(ADDR_MODE, rd);
		check_value("regfile dma status count zero", 16'h0001, rd);
	endtask

	// command, irq two edges later, status, track
	task automatic type1_command(input string name, input logic [7:0] cmd,
		input logic [7:0] exp_track);
		logic [15:0] rd;
		logic [7:0] b;
		set_mode(16'h0000);
		bus_write(ADDR_CTRL, 16'(cmd));
		check_value({name, " irq at write"}, 16'h0000, 16'(irq));
		wait_cycles(1);
		check_value({name, " irq one edge"}, 16'h0000, 16'(irq));
		wait_cycles(1);
		check_value({name, " irq two edges"}, 16'h0001, 16'(irq));
		bus_read(ADDR_CTRL, rd);
		check_value({name, " status"},
			16'(fdc_status_byte(1'b1, 1'b0, exp_track == 8'h00, 1'b0)), rd);
		check_value({name, " irq cleared"}, 16'h0000, 16'(irq));
		read_dio(5'd5, b);
		check_value({name, " track"}, 16'(exp_track), 16'(b));
	endtask

	task automatic type1_test();
		logic [31:0] r;
		logic [7:0] seek_trk;
		r = $urandom();
		// room to step either way without wrap
		seek_trk = {1'b0, r[6:0]} | 8'h08;
		set_mode(16'h0006);
		bus_write(ADDR_CTRL, 16'(seek_trk));
		type1_command("restore", 8'h00, 8'h00);
		type1_command("seek", 8'h10, seek_trk);
		type1_command("step in", 8'h40, seek_trk + 8'd1);
		type1_command("step out", 8'h60, seek_trk);
		type1_command("step repeat out", 8'h20, seek_trk - 8'd1);
		type1_command("step in again", 8'h40, seek_trk);
		type1_command("step repeat in", 8'h20, seek_trk + 8'd1);
		type1_command("restore again", 8'h03, 8'h00);
	endtask

	task automatic data_cmd_test();
		logic [31:0] r;
		logic [15:0] rd;
		logic [7:0] b;
		r = $urandom();
		set_mode(16'h0010);
		bus_write(ADDR_CTRL, 16'(r[7:0] | 8'h01));
		set_mode(16'h0000);
		// read sector parks on the io controller
		bus_write(ADDR_CTRL, 16'h0080);
		for (int i = 0; i < 20; i++) begin
			wait_cycles(1);
			check_value($sformatf("read sector irq cycle %0d", i), 16'h0000, 16'(irq));
			read_dio(5'd8, b);
			check_value($sformatf("read sector busy cycle %0d", i),
				16'(dio_flags(1'b0, drive_sel, drive_side, 1'b1)), 16'(b));
		end
		bus_read(ADDR_CTRL, rd);
		check_value("read sector status", 16'(fdc_status_byte(1'b1, 1'b0, 1'b0, 1'b1)), rd);
		dio_ack = 1'b1;
		wait_irq("read sector ack", ACK_TIMEOUT);
		read_dio(5'd3, b);
		check_value("read sector count cleared", 16'h0000, 16'(b));
		bus_read(ADDR_CTRL, rd);
		check_value("read sector done status",
			16'(fdc_status_byte(1'b1, 1'b0, 1'b0, 1'b0)), rd);
		check_value("read sector irq cleared", 16'h0000, 16'(irq));
		bus_read(ADDR_MODE, rd);
		check_value("read sector dma status", 16'h0001, rd);
		// let the synchronizer settle low
		dio_ack = 1'b0;
		wait_cycles(4);
		fdc_wr_prot = 1'b1;
		bus_write(ADDR_CTRL, 16'h00a0);
		wait_irq("protected write sector", ACK_TIMEOUT);
		bus_read(ADDR_CTRL, rd);
		check_value("protected write status",
			16'(fdc_status_byte(1'b1, 1'b1, 1'b0, 1'b0)), rd);
		check_value("protected write irq cleared", 16'h0000, 16'(irq));
		fdc_wr_prot = 1'b0;
	endtask

	// new command byte plus five random parameter bytes
	task automatic acsi_pick_bytes(output logic [31:0] r);
		logic [31:0] p;
		r = $urandom();
		p = $urandom();
		acsi_target = r[2:0];
		acsi_cmd_code = r[7:3];
		parm_bytes[0] = p[7:0];
		parm_bytes[1] = p[15:8];
		parm_bytes[2] = p[23:16];
		parm_bytes[3] = p[31:24];
		parm_bytes[4] = r[31:24];
	endtask

	task automatic acsi_auto_ack(input string name);
		logic [15:0] rd;
		check_value({name, " irq"}, 16'h0001, 16'(irq));
		bus_read(ADDR_CTRL, rd);
		check_value({name, " status"}, 16'h0000, rd);
		check_value({name, " irq cleared"}, 16'h0000, 16'(irq));
	endtask

	task automatic acsi_capture_check(input string name);
		logic [7:0] b;
		read_dio(5'd9, b);
		check_value({name, " target and cmd"}, 16'({acsi_target, acsi_cmd_code}), 16'(b));
		for (int i = 0; i < 5; i++) begin
			read_dio(5'(10 + i), b);
			check_value($sformatf("%s parm %0d", name, i), 16'(parm_bytes[i]), 16'(b));
		end
	endtask

	task automatic acsi_enabled_test();
		logic [31:0] r;
		logic [15:0] rd;
		logic [7:0] b;
		acsi_pick_bytes(r);
		acsi_enable = r[15:8] | (8'h01 << acsi_target);
		set_mode(16'h0008);
		bus_write(ADDR_CTRL, 16'({acsi_target, acsi_cmd_code}));
		acsi_auto_ack("acsi first byte");
		set_mode(16'h000a);
		for (int i = 0; i < 4; i++) begin
			bus_write(ADDR_CTRL, 16'(parm_bytes[i]));
			acsi_auto_ack($sformatf("acsi parm %0d", i));
		end
		// last byte goes to the io controller
		bus_write(ADDR_CTRL, 16'(parm_bytes[4]));
		check_value("acsi last byte irq", 16'h0000, 16'(irq));
		bus_read(ADDR_CTRL, rd);
		check_value("acsi last byte status", 16'h0008, rd);
		read_dio(5'd8, b);
		check_value("acsi last byte dio flags",
			16'(dio_flags(1'b1, drive_sel, drive_side, 1'b0)), 16'(b));
		dio_ack = 1'b1;
		wait_irq("acsi ack", ACK_TIMEOUT);
		bus_read(ADDR_CTRL, rd);
		check_value("acsi ack status", 16'h0000, rd);
		check_value("acsi ack irq cleared", 16'h0000, 16'(irq));
		read_dio(5'd8, b);
		check_value("acsi ack dio flags",
			16'(dio_flags(1'b0, drive_sel, drive_side, 1'b0)), 16'(b));
		dio_ack = 1'b0;
		wait_cycles(4);
		acsi_capture_check("acsi enabled");
	endtask

	task automatic acsi_disabled_test();
		logic [31:0] r;
		logic [15:0] rd;
		logic [7:0] b;
		acsi_pick_bytes(r);
		acsi_enable = r[15:8] & ~(8'h01 << acsi_target);
		drive_side = r[16];
		drive_sel = r[18:17];
		set_mode(16'h0008);
		bus_write(ADDR_CTRL, 16'({acsi_target, acsi_cmd_code}));
		check_value("acsi disabled first irq", 16'h0000, 16'(irq));
		set_mode(16'h000a);
		for (int i = 0; i < 5; i++) begin
			bus_write(ADDR_CTRL, 16'(parm_bytes[i]));
			check_value($sformatf("acsi disabled parm %0d irq", i), 16'h0000, 16'(irq));
		end
		bus_read(ADDR_CTRL, rd);
		check_value("acsi disabled status", 16'h0000, rd);
		read_dio(5'd8, b);
		check_value("acsi disabled dio flags",
			16'(dio_flags(1'b0, drive_sel, drive_side, 1'b0)), 16'(b));
		acsi_capture_check("acsi disabled");
	endtask

	initial begin
		// fixed seed for the whole run
		void'($urandom(41632));
		reset = 1'b1;
		bus_idle();
		fdc_wr_prot = 1'b0;
		acsi_enable = 8'h00;
		dio_idx = 5'd0;
		dio_ack = 1'b0;
		drive_side = 1'b0;
		drive_sel = 2'b00;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		regfile_test();
		type1_test();
		data_cmd_test();
		acsi_enabled_test();
		acsi_disabled_test();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
design/dma_pkg.sv
design/dma_regs.sv
design/fdc_emu.sv
design/acsi_cmd.sv
design/dio_status.sv
design/dma.sv
sim/dma_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = dma_tb
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
